// ==== common/rv_pkg.sv ====
package rv_pkg;

  // all integer registers and addresses are this wide.
  localparam int XLEN = 64;

  // major opcodes of the five supported instructions.
  localparam logic [6:0] OP_IMM = 7'b0010011; // addi lives here.
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] STORE  = 7'b0100011; // sd lives here.
  localparam logic [6:0] SYSTEM = 7'b1110011; // ebreak lives here.

  // minor function codes that split the opcodes above.
  localparam logic [2:0]  F3_ADDI    = 3'b000;
  localparam logic [2:0]  F3_SD      = 3'b011; // doubleword store.
  localparam logic [2:0]  F3_PRIV    = 3'b000; // ecall and ebreak share this funct3.
  localparam logic [11:0] F12_EBREAK = 12'h001; // ecall would be zero here.

  // register-immediate layout, used by addi and by the system group.
  typedef struct packed {
    logic [11:0] imm;    // the funct12 field for system words.
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // store layout; the immediate is split around the two sources.
  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0; // sits where rd would be.
    logic [6:0] opcode;
  } s_fmt_t;

  // upper immediate layout, used by auipc.
  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // jump layout, the immediate bits are scrambled by the isa.
  typedef struct packed {
    logic       imm_20;    // sign bit of the offset.
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through each of its layouts.
  typedef union packed {
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  // everything the decoder tells the rest of the core.
  typedef struct packed {
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;       // already sign extended.
    logic            need_imm;  // second adder operand is imm, not rs2.
    logic            alu_add;   // write back the adder result.
    logic            is_auipc;  // first adder operand is pc.
    logic            is_jal;
    logic            is_ebreak;
    logic            illegal;   // word is outside the supported set.
    logic            reg_wen;
    logic            mem_wen;
  } dec_ctrl_t;

  // store request presented to the data memory outside the core.
  typedef struct packed {
    logic            wen;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [7:0]      wmask; // one bit per byte lane.
  } store_req_t;

endpackage

// ==== decode/decoder.sv ====
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
  input  inst_t     inst,
  output dec_ctrl_t ctrl
);

  // opcode matches.
  logic op_imm;
  logic op_auipc;
  logic op_jal;
  logic op_store;
  logic op_system;

  // recognized instructions.
  logic addi;
  logic auipc;
  logic jal;
  logic sd;
  logic ebreak;

  // each format's immediate, sign extended to the full width.
  logic [XLEN-1:0] i_imm;
  logic [XLEN-1:0] s_imm;
  logic [XLEN-1:0] u_imm;
  logic [XLEN-1:0] j_imm;

  // the opcode sits in the same place in every view.
  assign op_imm    = (inst.i_fmt.opcode == OP_IMM);
  assign op_auipc  = (inst.i_fmt.opcode == AUIPC);
  assign op_jal    = (inst.i_fmt.opcode == JAL);
  assign op_store  = (inst.i_fmt.opcode == STORE);
  assign op_system = (inst.i_fmt.opcode == SYSTEM);

  assign addi   = op_imm & (inst.i_fmt.funct3 == F3_ADDI);
  assign auipc  = op_auipc; // no funct field to check.
  assign jal    = op_jal;
  assign sd     = op_store & (inst.s_fmt.funct3 == F3_SD);
  // for system words the immediate field carries funct12.
  assign ebreak = op_system & (inst.i_fmt.funct3 == F3_PRIV) &
                  (inst.i_fmt.imm == F12_EBREAK);

  assign i_imm = {{(XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign s_imm = {{(XLEN-12){inst.s_fmt.imm_11_5[6]}},
                  inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
  // auipc places its 20 bits on top of twelve zero bits.
  assign u_imm = {{(XLEN-32){inst.u_fmt.imm_31_12[19]}}, inst.u_fmt.imm_31_12, 12'b0};
  // jump offsets are always even, so bit 0 is implied.
  assign j_imm = {{(XLEN-21){inst.j_fmt.imm_20}}, inst.j_fmt.imm_20,
                  inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
                  inst.j_fmt.imm_10_1, 1'b0};

  always_comb begin
    ctrl = '0;

    // register indices are taken raw; unused ones are harmless.
    ctrl.rd  = inst.i_fmt.rd;
    ctrl.rs1 = inst.i_fmt.rs1;
    ctrl.rs2 = inst.s_fmt.rs2;

    // the instruction class picks which layout the immediate comes from.
    if (addi) begin
      ctrl.imm = i_imm;
    end else if (sd) begin
      ctrl.imm = s_imm;
    end else if (auipc) begin
      ctrl.imm = u_imm;
    end else if (jal) begin
      ctrl.imm = j_imm;
    end

    ctrl.need_imm  = addi | auipc | sd | jal; // nothing here reads rs2 into the adder.
    ctrl.alu_add   = addi | auipc;
    ctrl.is_auipc  = auipc;
    ctrl.is_jal    = jal;
    ctrl.is_ebreak = ebreak;
    ctrl.illegal   = ~(addi | auipc | jal | sd | ebreak);

    // sd and ebreak leave the register file alone.
    ctrl.reg_wen = addi | auipc | jal;
    ctrl.mem_wen = sd;
  end

endmodule

// ==== dv/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input logic            clk,
  input logic            rst_n,
  input logic [XLEN-1:0] pc,
  input store_req_t      store,
  input logic            illegal,
  input logic            halted,
  input logic            trap
);

  int error_count = 0; // number of assertion failures so far.

  // a halted core presents no store at all.
  no_store_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !store.wen)
    else begin
      $error("a store request was raised while the core is halted");
      error_count++;
    end

  // the pc is frozen on the stopping word.
  pc_frozen_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |=> $stable(pc))
    else begin
      $error("the pc moved while the core is halted");
      error_count++;
    end

  trap_needs_halt: assert property (@(posedge clk) disable iff (!rst_n)
    trap |-> halted)
    else begin
      $error("trap is set but the core is not halted");
      error_count++;
    end

  // an unknown word while running must lead to a trap one edge later.
  illegal_leads_to_trap: assert property (@(posedge clk) disable iff (!rst_n)
    (illegal && !halted) |=> (trap && halted))
    else begin
      $error("an illegal word did not stop the core with a trap");
      error_count++;
    end

  // the first edge after reset release still sees the reset pc.
  pc_starts_at_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> (pc == RESET_PC))
    else begin
      $error("the pc did not start at the reset address");
      error_count++;
    end

endmodule

bind rv_core rv_core_asserts #(.RESET_PC(RESET_PC)) u_rv_core_asserts (
  .clk     (clk),
  .rst_n   (rst_n),
  .pc      (pc),
  .store   (store),
  .illegal (illegal),
  .halted  (halted),
  .trap    (trap)
);

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  input  logic rerun, // a rising edge starts another reset.
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period.
  end

  // reset covers eight rising edges and is released on the falling edge after them.
  initial begin
    forever begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(posedge rerun); // wait until the testbench asks for a new run.
    end
  end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import rv_pkg::*; ();

  localparam logic [63:0] RESET_PC    = 64'h0000_0000_0000_1000;
  localparam int          PROG_LEN    = 64;
  localparam int          CYCLE_LIMIT = PROG_LEN * 4 + 50; // both runs fit well inside.
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam logic [31:0] UNIMP_WORD  = 32'h0000_3083;     // ld x1, 0(x0), not supported.

  // what the model expects the core to show in one cycle.
  typedef struct packed {
    store_req_t  store;
    logic        illegal;
    logic [63:0] next_pc;
    logic        next_halted;
    logic        next_trap;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        rerun;
  inst_t       inst;
  logic [63:0] pc;
  store_req_t  store;
  logic        illegal;
  logic        halted;
  logic        trap;

  logic [31:0] imem [0:PROG_LEN-1];  // program image, one word per entry.
  logic [63:0] model_regs [0:31];    // x0 is never written, so it stays zero.
  logic [63:0] model_pc;
  logic        model_halted;
  logic        model_trap;
  integer      seed;
  int          cycle_count = 0;

  tb_clock u_tb_clock (.rerun(rerun), .clk(clk), .rst_n(rst_n));

  rv_core #(.RESET_PC(RESET_PC)) u_rv_core (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .pc      (pc),
    .store   (store),
    .illegal (illegal),
    .halted  (halted),
    .trap    (trap)
  );

  // the memory answers with zero outside the program, which decodes as illegal.
  function automatic logic [31:0] fetch(input logic [63:0] addr);
    logic [63:0] offset;
    offset = addr - RESET_PC;
    if (addr < RESET_PC || offset[1:0] != 2'b00 || (offset >> 2) >= PROG_LEN) begin
      return 32'h0;
    end
    return imem[offset >> 2];
  endfunction

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopping on the first mismatch");
    end
  endtask

  // random mix of addi, sd, auipc and forward jal, closed by ebreak.
  task automatic build_program();
    int          kind;
    int          span;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [20:0] imm21;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind  = $unsigned($random(seed)) % 10;
      rd    = $unsigned($random(seed)) % 8; // x0 to x7, so x0 gets written too.
      rs1   = $unsigned($random(seed)) % 8;
      rs2   = $unsigned($random(seed)) % 8;
      imm12 = $random(seed);
      if (kind < 4) begin
        imem[i] = {imm12, rs1, F3_ADDI, rd, OP_IMM};
      end else if (kind < 6) begin
        imem[i] = {imm12[11:5], rs2, rs1, F3_SD, imm12[4:0], STORE};
      end else if (kind < 8) begin
        imem[i] = {20'($random(seed)), rd, AUIPC};
      end else begin
        // jumps only go forward and never past the final word.
        span = 1 + ($unsigned($random(seed)) % 3);
        if (span > PROG_LEN - 1 - i) begin
          span = PROG_LEN - 1 - i;
        end
        imm21   = 21'(span * 4);
        imem[i] = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, JAL};
      end
    end
    imem[PROG_LEN-1] = EBREAK_WORD;
  endtask

  task automatic model_reset();
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    model_pc     = RESET_PC;
    model_halted = 1'b0;
    model_trap   = 1'b0;
  endtask

  // reference step, decoding the word straight from the isa field layout.
  function automatic expect_t model_step(input logic [31:0] w);
    expect_t     e;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    logic [63:0] wb;
    logic        wr;
    op    = w[6:0];
    f3    = w[14:12];
    rd    = w[11:7];
    src1  = model_regs[w[19:15]];
    src2  = model_regs[w[24:20]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_u = {{32{w[31]}}, w[31:12], 12'b0};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e     = '0;
    wr    = 1'b0;
    wb    = '0;
    e.next_pc     = model_pc + 64'd4;
    e.next_halted = model_halted;
    e.next_trap   = model_trap;
    if (op == OP_IMM && f3 == F3_ADDI) begin
      wr = 1'b1;
      wb = src1 + imm_i;
    end else if (op == AUIPC) begin
      wr = 1'b1;
      wb = model_pc + imm_u;
    end else if (op == JAL) begin
      wr        = 1'b1;
      wb        = model_pc + 64'd4; // return address.
      e.next_pc = model_pc + imm_j;
    end else if (op == STORE && f3 == F3_SD) begin
      e.store.wen   = 1'b1;
      e.store.addr  = src1 + imm_s;
      e.store.wdata = src2;
      e.store.wmask = 8'hff;
    end else if (op == SYSTEM && f3 == F3_PRIV && w[31:20] == F12_EBREAK) begin
      e.next_halted = 1'b1;
      e.next_pc     = model_pc; // pc stays on the ebreak.
    end else begin
      e.illegal     = 1'b1;
      e.next_halted = 1'b1;
      e.next_trap   = 1'b1;
      e.next_pc     = model_pc;
    end
    if (model_halted) begin
      // once stopped nothing changes; illegal still follows the word.
      e.store       = '0;
      e.next_pc     = model_pc;
      e.next_halted = 1'b1;
      e.next_trap   = model_trap;
      wr            = 1'b0;
    end
    if (wr && rd != 5'd0) begin
      model_regs[rd] = wb;
    end
    return e;
  endfunction

  // compares the core with the model once per cycle until it has sat halted a while.
  task automatic run_program(input logic expect_trap);
    expect_t e;
    int      idle;
    model_reset();
    idle = 0;
    inst = fetch(RESET_PC);
    wait (rst_n === 1'b1);
    while (idle < 4) begin
      #20; // well inside the low phase, all outputs have settled.
      check("pc", pc, model_pc);
      check("halted", halted, model_halted);
      check("trap", trap, model_trap);
      e = model_step(fetch(model_pc));
      check("illegal", illegal, e.illegal);
      check("store.wen", store.wen, e.store.wen);
      check("store.addr", store.addr, e.store.addr);
      check("store.wdata", store.wdata, e.store.wdata);
      check("store.wmask", store.wmask, e.store.wmask);
      if (model_halted) begin
        idle++;
      end
      model_pc     = e.next_pc;
      model_halted = e.next_halted;
      model_trap   = e.next_trap;
      @(negedge clk);
      inst = fetch(pc); // the memory answers the pc of the new cycle.
    end
    check("halted at end", halted, 1'b1);
    check("trap at end", trap, expect_trap);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the core did not finish its programs within %0d cycles", CYCLE_LIMIT);
      $display("Regression failed");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    seed  = 32'h13f3_a566;
    rerun = 1'b0;
    inst  = '0;
    build_program();
    run_program(1'b0); // first run stops on ebreak.
    imem[PROG_LEN-1] = UNIMP_WORD;
    @(negedge clk);
    rerun = 1'b1;
    wait (rst_n === 1'b0);
    rerun = 1'b0;
    run_program(1'b1); // second run stops on the unknown word.
    // the bound checker counts its own failures.
    if (u_rv_core.u_rv_core_asserts.error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import rv_pkg::*; (
  input  dec_ctrl_t       ctrl,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rs1_val,
  input  logic [XLEN-1:0] rs2_val,
  output logic [XLEN-1:0] wb_data,
  output logic [XLEN-1:0] next_pc,
  output store_req_t      store
);

  logic [XLEN-1:0] op_a;   // first adder operand.
  logic [XLEN-1:0] op_b;   // second adder operand.
  logic [XLEN-1:0] sum;    // the one general adder.
  logic [XLEN-1:0] link;   // address of the next sequential word.
  logic [XLEN-1:0] target; // jal destination.

  // auipc adds to the pc, everything else adds to rs1.
  assign op_a = ctrl.is_auipc ? pc : rs1_val;
  assign op_b = ctrl.need_imm ? ctrl.imm : rs2_val;
  assign sum  = op_a + op_b; // serves addi, auipc and the sd address.

  assign link   = pc + XLEN'(4);
  assign target = pc + ctrl.imm;

  // only jal leaves the sequential path.
  assign next_pc = ctrl.is_jal ? target : link;

  always_comb begin
    if (ctrl.is_jal) begin
      wb_data = link; // jal saves its return address.
    end else if (ctrl.alu_add) begin
      wb_data = sum;
    end else begin
      wb_data = '0; // nothing is written back in this case.
    end
  end

  // a store that is not taking place is kept all zero.
  always_comb begin
    store = '0;
    if (ctrl.mem_wen) begin
      store.wen   = 1'b1;
      store.addr  = sum;     // rs1 plus the store offset.
      store.wdata = rs2_val; // sd sends the whole register.
      store.wmask = 8'hff;   // all eight byte lanes for a doubleword.
    end
  end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  logic [4:0]      rd,
  input  logic            wen,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rs1_val,
  output logic [XLEN-1:0] rs2_val
);

  // x0 has no storage, only x1 to x31 are kept.
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0; // every register starts at zero.
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= wdata; // a write to x0 is dropped here.
    end
  end

  // reads are combinational and see the value from before the edge.
  // there is no bypass from the write port, which is fine because
  // a single-cycle core never reads what it writes in the same cycle.
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_val = '0;
    end else begin
      rs1_val = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == 5'd0) begin
      rs2_val = '0;
    end else begin
      rs2_val = regs[rs2];
    end
  end

endmodule

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic            clk,
  input  logic            rst_n,
  input  inst_t           inst,    // returned by the outside for the current pc.
  output logic [XLEN-1:0] pc,
  output store_req_t      store,
  output logic            illegal,
  output logic            halted,
  output logic            trap
);

  dec_ctrl_t       ctrl;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] wb_data;
  logic [XLEN-1:0] next_pc;
  store_req_t      exec_store; // store request before the running gate.
  logic            running;
  logic            stop;       // this word ends execution at the next edge.
  logic            rf_wen;

  decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (ctrl.rs1),
    .rs2     (ctrl.rs2),
    .rd      (ctrl.rd),
    .wen     (rf_wen),
    .wdata   (wb_data),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  exec_unit u_exec_unit (
    .ctrl    (ctrl),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb_data (wb_data),
    .next_pc (next_pc),
    .store   (exec_store)
  );

  assign running = ~halted;

  // both ebreak and an unknown word stop the core.
  assign stop = running & (ctrl.is_ebreak | ctrl.illegal);

  // nothing architectural changes once the core is halted.
  assign rf_wen = ctrl.reg_wen & running;

  // a halted core presents an all-zero request, not just a low wen.
  assign store = running ? exec_store : '0;

  // raw decoder output, valid in the same cycle as the word.
  assign illegal = ctrl.illegal;

  // the pc stays on the stopping word so the outside can see where it ended.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (running && !stop) begin
      pc <= next_pc; // one instruction per cycle.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (stop) begin
      halted <= 1'b1;
      trap   <= ctrl.illegal; // ebreak stops cleanly without a trap.
    end
  end

endmodule

// ==== sim.f ====
common/rv_pkg.sv
decode/decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/rv_core.sv
dv/tb_clock.sv
dv/rv_core_asserts.sv
dv/tb_top.sv
